//--- common/ex_pkg.sv
// Shared execute stage types: data word, register address, ALU and multiplier operators
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////

  // Operand and result word of the integer datapath
  typedef logic [31:0] data_t;

  // Register file write address
  // MSB selects the floating point bank, kept for port compatibility
  typedef logic [5:0] reg_addr_t;

  ////////////////////////////////////////////////////////////
  // ALU operators
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    // Arithmetic and logic
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    // Shifts
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    // Set less than, result is 0 or 1
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9,
    // Branch comparisons, drive the compare bit only
    ALU_EQ   = 5'd10,
    ALU_NE   = 5'd11,
    ALU_LT   = 5'd12,
    ALU_GE   = 5'd13,
    ALU_LTU  = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Multiplier operators
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // Low 32 bits of the product, single cycle
    MUL_LO  = 2'd0,
    // High 32 bits, signed x signed
    MUL_H   = 2'd1,
    // High 32 bits, signed x unsigned
    MUL_HSU = 2'd2,
    // High 32 bits, unsigned x unsigned
    MUL_HU  = 2'd3
  } mult_op_e;

endpackage

`default_nettype wire

//--- common/ex_result_if.sv
// Result and readiness bundle between the execute units and the write-back logic
`timescale 1ns/10ps
`default_nettype none

interface ex_result_if import ex_pkg::*; ();

  // Combinational ALU result
  data_t alu_result;
  // Multiplier result, low product or finished high product
  data_t mult_result;
  // Multiplier can accept a new operation or has a result ready
  logic  mult_ready;
  // Stage readiness, seen by the multiplier to leave its finished state
  logic  ex_ready;

  modport alu (
    output alu_result
  );

  modport mult (
    output mult_result,
    output mult_ready,
    input  ex_ready
  );

  modport wb (
    input  alu_result,
    input  mult_result,
    input  mult_ready,
    output ex_ready
  );

endinterface

`default_nettype wire

//--- alu/ex_alu.sv
// Integer ALU: shared adder and comparator, shifter, logic ops and branch compare
`timescale 1ns/10ps
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  alu_op_e  operator_i,
  input  data_t    operand_a_i,
  input  data_t    operand_b_i,
  output logic     cmp_result_o,
  ex_result_if.alu res
);

  ////////////////////////////////////////////////////////////
  // Shared adder and comparator
  ////////////////////////////////////////////////////////////

  logic        is_sub;
  logic        is_signed;
  logic [32:0] a_ext;
  logic [32:0] b_ext;
  logic [32:0] adder_sum;
  logic        is_equal;
  logic        is_less;

  // Subtraction for SUB and every ordered compare
  assign is_sub = (operator_i == ALU_SUB)  || (operator_i == ALU_SLT) ||
                  (operator_i == ALU_SLTU) || (operator_i == ALU_LT)  ||
                  (operator_i == ALU_GE)   || (operator_i == ALU_LTU) ||
                  (operator_i == ALU_GEU);

  assign is_signed = (operator_i == ALU_SLT) || (operator_i == ALU_LT) ||
                     (operator_i == ALU_GE);

  // 33 bit operands, sign bit only for signed compares
  assign a_ext = {is_signed & operand_a_i[31], operand_a_i};
  assign b_ext = {is_signed & operand_b_i[31], operand_b_i};

  // Invert and add one for subtraction
  assign adder_sum = a_ext + (b_ext ^ {33{is_sub}}) + {32'd0, is_sub};

  // Difference of two extended values cannot overflow, so bit 32 is the sign
  assign is_less  = adder_sum[32];
  assign is_equal = (operand_a_i == operand_b_i);

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  logic               shift_left;
  logic               shift_arith;
  logic [4:0]         shift_amt;
  data_t              shift_src;
  logic signed [32:0] shift_in;
  logic [32:0]        shift_out;
  data_t              shift_result;

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);
  assign shift_amt   = operand_b_i[4:0];

  // Left shift runs through the right shifter on bit-reversed data
  always_comb begin
    for (int i = 0; i < 32; i++) begin
      shift_src[i] = shift_left ? operand_a_i[31-i] : operand_a_i[i];
    end
  end

  assign shift_in  = {shift_arith & operand_a_i[31], shift_src};
  assign shift_out = shift_in >>> shift_amt;

  always_comb begin
    for (int i = 0; i < 32; i++) begin
      shift_result[i] = shift_left ? shift_out[31-i] : shift_out[i];
    end
  end

  ////////////////////////////////////////////////////////////
  // Result and branch compare
  ////////////////////////////////////////////////////////////

  always_comb begin
    cmp_result_o = 1'b0;
    unique case (operator_i)
      ALU_EQ:           cmp_result_o = is_equal;
      ALU_NE:           cmp_result_o = ~is_equal;
      ALU_LT, ALU_LTU:  cmp_result_o = is_less;
      ALU_GE, ALU_GEU:  cmp_result_o = ~is_less;
      default:          cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    res.alu_result = '0;
    unique case (operator_i)
      ALU_ADD, ALU_SUB:          res.alu_result = adder_sum[31:0];
      ALU_AND:                   res.alu_result = operand_a_i & operand_b_i;
      ALU_OR:                    res.alu_result = operand_a_i | operand_b_i;
      ALU_XOR:                   res.alu_result = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: res.alu_result = shift_result;
      ALU_SLT, ALU_SLTU:         res.alu_result = {31'd0, is_less};
      // Compare operators also expose their bit on the result word
      default:                   res.alu_result = {31'd0, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

//--- mult/ex_mult.sv
// Multiplier: single cycle low product, three cycle sequenced high product
`timescale 1ns/10ps
`default_nettype none

module ex_mult import ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       enable_i,
  input  mult_op_e   operator_i,
  input  data_t      op_a_i,
  input  data_t      op_b_i,
  output logic       multicycle_o,
  ex_result_if.mult  res
);

  typedef enum logic [1:0] {
    MULH_IDLE   = 2'd0,
    MULH_STEP   = 2'd1,
    MULH_FINISH = 2'd2
  } mulh_state_e;

  mulh_state_e        state_q;
  mulh_state_e        state_d;

  logic               is_high;
  logic               start;
  logic               a_sign;
  logic               b_sign;
  logic signed [32:0] a_ext;
  logic signed [16:0] b_part;
  logic signed [49:0] part_prod;
  logic signed [65:0] part_ext;
  logic signed [65:0] acc_q;
  data_t              lo_prod;

  ////////////////////////////////////////////////////////////
  // Low product
  ////////////////////////////////////////////////////////////

  // Signedness does not affect the low 32 bits
  assign lo_prod = op_a_i * op_b_i;

  ////////////////////////////////////////////////////////////
  // High product datapath
  ////////////////////////////////////////////////////////////

  assign is_high = (operator_i != MUL_LO);
  assign start   = enable_i && is_high && (state_q == MULH_IDLE);

  // Sign or zero extension to 33 bits
  assign a_sign = (operator_i == MUL_H || operator_i == MUL_HSU) & op_a_i[31];
  assign b_sign = (operator_i == MUL_H) & op_b_i[31];
  assign a_ext  = {a_sign, op_a_i};

  // First cycle takes the unsigned low half of B
  // Second cycle takes the signed upper 17 bits
  assign b_part = (state_q == MULH_IDLE) ? {1'b0, op_b_i[15:0]} : {b_sign, op_b_i[31:16]};

  // One 33 x 17 multiplier shared by both cycles
  assign part_prod = a_ext * b_part;
  assign part_ext  = part_prod;

  // Partial product accumulator, operands held stable by ID meanwhile
  always_ff @(posedge clk) begin
    if (start) begin
      acc_q <= part_ext;
    end else if (state_q == MULH_STEP) begin
      acc_q <= acc_q + (part_ext <<< 16);
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MULH_IDLE: begin
        if (start) begin
          state_d = MULH_STEP;
        end
      end
      MULH_STEP: begin
        state_d = MULH_FINISH;
      end
      MULH_FINISH: begin
        // Hold the result until the stage moves on
        if (res.ex_ready) begin
          state_d = MULH_IDLE;
        end
      end
      default: begin
        state_d = MULH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Busy during the first two cycles of a high multiply
  assign multicycle_o   = start || (state_q == MULH_STEP);
  assign res.mult_ready = !multicycle_o;

  // Upper half of the 64 bit product once finished
  assign res.mult_result = (state_q == MULH_FINISH) ? acc_q[63:32] : lo_prod;

endmodule

`default_nettype wire

//--- verilog/ex_writeback.sv
// Forwarding write-port mux, EX/WB register and stage ready/valid logic
`timescale 1ns/10ps
`default_nettype none

module ex_writeback import ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  ex_result_if.wb    res,

  // Unit enables from ID
  input  logic       alu_en_i,
  input  logic       mult_en_i,
  input  logic       csr_access_i,
  input  logic       lsu_en_i,

  input  data_t      csr_rdata_i,

  // Forwarding port controls
  input  logic       regfile_alu_we_i,
  input  reg_addr_t  regfile_alu_waddr_i,

  // LSU write port controls
  input  logic       regfile_we_i,
  input  reg_addr_t  regfile_waddr_i,
  input  data_t      lsu_rdata_i,
  input  logic       lsu_ready_ex_i,
  input  logic       lsu_err_i,

  input  logic       branch_in_ex_i,
  input  logic       wb_ready_i,

  output logic       regfile_alu_we_fw_o,
  output reg_addr_t  regfile_alu_waddr_fw_o,
  output data_t      regfile_alu_wdata_fw_o,

  output logic       regfile_we_wb_o,
  output reg_addr_t  regfile_waddr_wb_o,
  output data_t      regfile_wdata_wb_o,

  output logic       ex_ready_o,
  output logic       ex_valid_o
);

  logic write_keep;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = res.mult_result;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = res.alu_result;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX/WB register for the LSU port
  ////////////////////////////////////////////////////////////

  // Faulting load or store never writes back
  assign write_keep = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else if (ex_valid_o) begin
      regfile_we_wb_o <= write_keep;
      if (write_keep) begin
        regfile_waddr_wb_o <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Bubble moves into WB
      regfile_we_wb_o <= 1'b0;
    end
  end

  // Load data arrives in WB directly from the LSU
  assign regfile_wdata_wb_o = lsu_rdata_i;

  ////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////

  // Branches resolve in EX and need no WB slot
  assign ex_ready_o = (res.mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) &
                      (res.mult_ready & lsu_ready_ex_i & wb_ready_i);

  assign res.ex_ready = ex_ready_o;

endmodule

`default_nettype wire

//--- verilog/ex_stage.sv
// Execute stage top level: ALU, multiplier and write-back block
`timescale 1ns/10ps
`default_nettype none

module ex_stage import ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // ALU operands from ID
  input  logic       alu_en_i,
  input  alu_op_e    alu_operator_i,
  input  data_t      alu_operand_a_i,
  input  data_t      alu_operand_b_i,
  input  data_t      alu_operand_c_i,

  // Multiplier operands from ID
  input  logic       mult_en_i,
  input  mult_op_e   mult_operator_i,
  input  data_t      mult_operand_a_i,
  input  data_t      mult_operand_b_i,
  output logic       mult_multicycle_o,

  // CSR read
  input  logic       csr_access_i,
  input  data_t      csr_rdata_i,

  // LSU
  input  logic       lsu_en_i,
  input  data_t      lsu_rdata_i,
  input  logic       lsu_ready_ex_i,
  input  logic       lsu_err_i,

  // Control from ID
  input  logic       branch_in_ex_i,
  input  logic       regfile_alu_we_i,
  input  reg_addr_t  regfile_alu_waddr_i,
  input  logic       regfile_we_i,
  input  reg_addr_t  regfile_waddr_i,
  input  logic       wb_ready_i,

  // Write-back port
  output logic       regfile_we_wb_o,
  output reg_addr_t  regfile_waddr_wb_o,
  output data_t      regfile_wdata_wb_o,

  // Forwarding port to ID and register file
  output logic       regfile_alu_we_fw_o,
  output reg_addr_t  regfile_alu_waddr_fw_o,
  output data_t      regfile_alu_wdata_fw_o,

  // Branch target and decision to IF
  output data_t      jump_target_o,
  output logic       branch_decision_o,

  output logic       ex_ready_o,
  output logic       ex_valid_o
);

  ex_result_if res_if ();

  // Target is computed in ID and carried on operand C
  assign jump_target_o = alu_operand_c_i;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  ex_alu alu_i (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .cmp_result_o (branch_decision_o),
    .res          (res_if.alu)
  );

  ////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .multicycle_o (mult_multicycle_o),
    .res          (res_if.mult)
  );

  ////////////////////////////////////////////////////////////
  // Write-back and handshake
  ////////////////////////////////////////////////////////////

  ex_writeback writeback_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .res                    (res_if.wb),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

//--- bench/ex_ref_model.svh
// Reference models for ALU results, branch decisions and multiplier products
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Branch outcome for the six compare operators
function automatic logic branch_model(input alu_op_e op, input data_t a, input data_t b);
  case (op)
    ALU_EQ:  return a == b;
    ALU_NE:  return a != b;
    ALU_LT:  return $signed(a) < $signed(b);
    ALU_GE:  return $signed(a) >= $signed(b);
    ALU_LTU: return a < b;
    ALU_GEU: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// Result word of the arithmetic, logic, shift and set-less-than operators
function automatic data_t alu_model(input alu_op_e op, input data_t a, input data_t b);
  case (op)
    ALU_ADD:  return a + b;
    ALU_SUB:  return a - b;
    ALU_AND:  return a & b;
    ALU_OR:   return a | b;
    ALU_XOR:  return a ^ b;
    // Shift amount is the low five bits of B
    ALU_SLL:  return a << b[4:0];
    ALU_SRL:  return a >> b[4:0];
    ALU_SRA:  return $signed(a) >>> b[4:0];
    ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
    ALU_SLTU: return {31'd0, a < b};
    default:  return {31'd0, branch_model(op, a, b)};
  endcase
endfunction

// Full 64 bit product, low or high half by operator
function automatic data_t mult_model(input mult_op_e op, input data_t a, input data_t b);
  logic [63:0] a_wide;
  logic [63:0] b_wide;
  logic [63:0] prod;
  // Operand A is signed for MUL_H and MUL_HSU
  a_wide = (op == MUL_H || op == MUL_HSU) ? {{32{a[31]}}, a} : {32'd0, a};
  // Operand B is signed for MUL_H only
  b_wide = (op == MUL_H) ? {{32{b[31]}}, b} : {32'd0, b};
  prod   = a_wide * b_wide;
  if (op == MUL_LO) begin
    return prod[31:0];
  end
  return prod[63:32];
endfunction

`endif

//--- bench/tb_ex_stage.sv
// Execute stage testbench with clock, reset, LFSR, directed tests, watchdog and report
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

  `include "ex_ref_model.svh"

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 4;
  localparam logic [31:0] LFSR_SEED    = 32'hbfac_d7dc;
  localparam int          ALU_PAIRS    = 40;
  localparam int          BR_PAIRS     = 8;
  localparam int          MUL_PAIRS    = 6;
  // Rough cycle budget with about five cycles per high multiply
  localparam int TOTAL_CYCLES = RESET_CYCLES + 10 * ALU_PAIRS + 6 * (BR_PAIRS + 2) +
                                MUL_PAIRS + 3 * (MUL_PAIRS + 4) * 5 + 40;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      alu_en_i, mult_en_i, csr_access_i, lsu_en_i;
  alu_op_e   alu_operator_i;
  mult_op_e  mult_operator_i;
  data_t     alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  data_t     mult_operand_a_i, mult_operand_b_i, csr_rdata_i, lsu_rdata_i;
  logic      lsu_ready_ex_i, lsu_err_i, branch_in_ex_i, wb_ready_i;
  logic      regfile_alu_we_i, regfile_we_i;
  reg_addr_t regfile_alu_waddr_i, regfile_waddr_i;
  logic      mult_multicycle_o, regfile_we_wb_o, regfile_alu_we_fw_o;
  reg_addr_t regfile_waddr_wb_o, regfile_alu_waddr_fw_o;
  data_t     regfile_wdata_wb_o, regfile_alu_wdata_fw_o, jump_target_o;
  logic      branch_decision_o, ex_ready_o, ex_valid_o;

  logic [31:0] lfsr_q;
  int          error_count;
  int          check_count;

  ex_stage ex_stage_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic data_t rand_bits(input int n);
    data_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], next_lfsr_bit()};
    end
    return r;
  endfunction

  task automatic compare(input data_t got, input data_t exp, input string what);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // No unit enabled with LSU and WB ready
  task automatic drive_idle();
    alu_en_i <= 1'b0;
    mult_en_i <= 1'b0;
    csr_access_i <= 1'b0;
    lsu_en_i <= 1'b0;
    alu_operator_i <= ALU_ADD;
    mult_operator_i <= MUL_LO;
    alu_operand_a_i <= '0;
    alu_operand_b_i <= '0;
    alu_operand_c_i <= '0;
    mult_operand_a_i <= '0;
    mult_operand_b_i <= '0;
    csr_rdata_i <= '0;
    lsu_rdata_i <= '0;
    lsu_ready_ex_i <= 1'b1;
    lsu_err_i <= 1'b0;
    branch_in_ex_i <= 1'b0;
    wb_ready_i <= 1'b1;
    regfile_alu_we_i <= 1'b0;
    regfile_alu_waddr_i <= '0;
    regfile_we_i <= 1'b0;
    regfile_waddr_i <= '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_values();
    compare(regfile_we_wb_o, 1'b0, "WB enable after reset");
    compare(regfile_waddr_wb_o, '0, "WB address after reset");
    compare(mult_multicycle_o, 1'b0, "multicycle after reset");
  endtask

  // Operators 0 to 9 are the non-compare ones
  task automatic alu_ops_sweep();
    alu_op_e   op;
    data_t     a, b;
    logic      we;
    reg_addr_t addr;
    for (int k = 0; k < 10; k++) begin
      op = alu_op_e'(k);
      for (int i = 0; i < ALU_PAIRS; i++) begin
        a    = rand_bits(32);
        b    = rand_bits(32);
        we   = next_lfsr_bit();
        addr = reg_addr_t'(rand_bits(6));
        @(posedge clk);
        alu_en_i <= 1'b1;
        alu_operator_i <= op;
        alu_operand_a_i <= a;
        alu_operand_b_i <= b;
        regfile_alu_we_i <= we;
        regfile_alu_waddr_i <= addr;
        @(negedge clk);
        compare(regfile_alu_wdata_fw_o, alu_model(op, a, b), op.name());
        compare(regfile_alu_we_fw_o, we, "forwarding write enable");
        compare(regfile_alu_waddr_fw_o, addr, "forwarding address");
      end
    end
    @(posedge clk);
    drive_idle();
  endtask

  // Last pair of each operator has equal operands
  task automatic branch_sweep();
    alu_op_e op;
    data_t   a, b, c;
    for (int k = 10; k < 16; k++) begin
      op = alu_op_e'(k);
      for (int i = 0; i <= BR_PAIRS; i++) begin
        a = rand_bits(32);
        b = (i == BR_PAIRS) ? a : rand_bits(32);
        c = rand_bits(32);
        @(posedge clk);
        alu_en_i <= 1'b1;
        alu_operator_i <= op;
        alu_operand_a_i <= a;
        alu_operand_b_i <= b;
        alu_operand_c_i <= c;
        @(negedge clk);
        compare(branch_decision_o, branch_model(op, a, b), op.name());
        compare(regfile_alu_wdata_fw_o, alu_model(op, a, b), "compare result word");
        compare(jump_target_o, c, "jump target");
      end
    end
    // A branch needs no WB slot
    @(posedge clk);
    branch_in_ex_i <= 1'b1;
    wb_ready_i <= 1'b0;
    @(negedge clk);
    compare(ex_ready_o, 1'b1, "ex_ready with branch in EX");
    compare(ex_valid_o, 1'b0, "ex_valid with WB stalled");
    @(posedge clk);
    drive_idle();
  endtask

  // Issue one high multiply and count the busy cycles
  task automatic high_multiply(input mult_op_e op, input data_t a, input data_t b);
    int busy;
    @(posedge clk);
    mult_en_i <= 1'b1;
    mult_operator_i <= op;
    mult_operand_a_i <= a;
    mult_operand_b_i <= b;
    busy = 0;
    @(negedge clk);
    while (mult_multicycle_o && busy < 8) begin
      compare(ex_ready_o, 1'b0, "ex_ready during multiply");
      busy++;
      @(negedge clk);
    end
    compare(busy, 2, "high multiply busy cycles");
    compare(ex_valid_o, 1'b1, "ex_valid after multiply");
    compare(regfile_alu_wdata_fw_o, mult_model(op, a, b), op.name());
    @(posedge clk);
    mult_en_i <= 1'b0;
  endtask

  task automatic multiply_sweep();
    mult_op_e op;
    data_t    a, b;
    for (int i = 0; i < MUL_PAIRS; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      @(posedge clk);
      mult_en_i <= 1'b1;
      mult_operator_i <= MUL_LO;
      mult_operand_a_i <= a;
      mult_operand_b_i <= b;
      @(negedge clk);
      compare(regfile_alu_wdata_fw_o, mult_model(MUL_LO, a, b), "MUL_LO");
      compare(mult_multicycle_o, 1'b0, "multicycle on MUL_LO");
      compare(ex_ready_o, 1'b1, "ex_ready on MUL_LO");
    end
    @(posedge clk);
    drive_idle();
    for (int k = 1; k < 4; k++) begin
      op = mult_op_e'(k);
      for (int i = 0; i < MUL_PAIRS; i++) begin
        high_multiply(op, rand_bits(32), rand_bits(32));
      end
      // Extreme signed values
      high_multiply(op, 32'h8000_0000, 32'h8000_0000);
      high_multiply(op, 32'h8000_0000, 32'h7fff_ffff);
      high_multiply(op, 32'hffff_ffff, 32'hffff_ffff);
      high_multiply(op, 32'h7fff_ffff, 32'h8000_0000);
    end
  endtask

  task automatic back_pressure();
    data_t a, b;
    int    n;
    a = rand_bits(32);
    b = rand_bits(32);
    @(posedge clk);
    wb_ready_i <= 1'b0;
    mult_en_i <= 1'b1;
    mult_operator_i <= MUL_H;
    mult_operand_a_i <= a;
    mult_operand_b_i <= b;
    n = 0;
    @(negedge clk);
    while (mult_multicycle_o && n < 8) begin
      n++;
      @(negedge clk);
    end
    // Finished result is held while WB stalls
    repeat (3) begin
      compare(regfile_alu_wdata_fw_o, mult_model(MUL_H, a, b), "held product");
      compare(ex_valid_o, 1'b0, "ex_valid under back-pressure");
      @(negedge clk);
    end
    @(posedge clk);
    wb_ready_i <= 1'b1;
    @(negedge clk);
    compare(ex_valid_o, 1'b1, "ex_valid after WB ready");
    compare(regfile_alu_wdata_fw_o, mult_model(MUL_H, a, b), "product after stall");
    @(posedge clk);
    drive_idle();
  endtask

  task automatic exwb_register();
    reg_addr_t addr;
    data_t     rd;
    addr = reg_addr_t'(rand_bits(6));
    rd   = rand_bits(32);
    @(posedge clk);
    lsu_en_i <= 1'b1;
    regfile_we_i <= 1'b1;
    regfile_waddr_i <= addr;
    lsu_rdata_i <= rd;
    @(negedge clk);
    compare(ex_valid_o, 1'b1, "ex_valid on LSU op");
    compare(regfile_wdata_wb_o, rd, "WB data from LSU");
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    compare(regfile_we_wb_o, 1'b1, "WB enable after valid");
    compare(regfile_waddr_wb_o, addr, "WB address after valid");
    @(negedge clk);
    compare(regfile_we_wb_o, 1'b0, "WB enable after idle cycle");
    // Faulting access must not write or move the address
    @(posedge clk);
    lsu_en_i <= 1'b1;
    regfile_we_i <= 1'b1;
    lsu_err_i <= 1'b1;
    regfile_waddr_i <= ~addr;
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    compare(regfile_we_wb_o, 1'b0, "WB enable on LSU error");
    compare(regfile_waddr_wb_o, addr, "WB address on LSU error");
  endtask

  task automatic mux_priority();
    data_t c;
    c = rand_bits(32);
    @(posedge clk);
    csr_access_i <= 1'b1;
    csr_rdata_i <= c;
    mult_en_i <= 1'b1;
    alu_en_i <= 1'b1;
    mult_operand_a_i <= rand_bits(32);
    mult_operand_b_i <= rand_bits(32);
    @(negedge clk);
    compare(regfile_alu_wdata_fw_o, c, "CSR over multiplier");
    @(posedge clk);
    lsu_ready_ex_i <= 1'b0;
    @(negedge clk);
    compare(ex_valid_o, 1'b0, "ex_valid with LSU busy");
    compare(ex_ready_o, 1'b0, "ex_ready with LSU busy");
    @(posedge clk);
    drive_idle();
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence, watchdog and report
  ////////////////////////////////////////////////////////////

  initial begin
    error_count = 0;
    check_count = 0;
    lfsr_q      = LFSR_SEED;
    rst_n       = 1'b0;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_values();
    alu_ops_sweep();
    branch_sweep();
    multiply_sweep();
    back_pressure();
    exwb_register();
    mux_priority();
    @(posedge clk);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(TOTAL_CYCLES * 2 * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d ns", TOTAL_CYCLES * 2 * CLK_PERIOD);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+bench
common/ex_pkg.sv
common/ex_result_if.sv
alu/ex_alu.sv
mult/ex_mult.sv
verilog/ex_writeback.sv
verilog/ex_stage.sv
bench/tb_ex_stage.sv
